/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rename
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
EXE       ?= sim_rename
VFLAGS    ?= --timing
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(EXE)
	@out="$$(./$(BUILD_DIR)/$(EXE))"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* rtl/arch_pkg.sv */
`default_nettype none

`include "rename_cfg.svh"

package arch_pkg;

        // one architectural register index
        typedef logic [`ARF_NUM_WIDTH-1:0] arch_reg_t;

        // one rename request, dest in the upper bits
        typedef struct packed {
                arch_reg_t dest;
                arch_reg_t src;
        } rename_req_t;

endpackage

`default_nettype wire

/* rtl/freelist.sv */
`default_nettype none

`include "rename_cfg.svh"

module freelist (
        input  logic   clk,
        input  logic   reset,
        free_if.provider port
);
        import prf_pkg::*;

        // tags backing the reset map start out busy
        localparam prf_vec_t busy_init = prf_vec_t'({`ARF_NUM{1'b1}});

        prf_vec_t busy_q;
        logic     enc_valid;
        prf_tag_t enc_tag;

        freelist_enc64 i_enc (
                .free_list  (busy_q),
                .free_valid (enc_valid),
                .free_num   (enc_tag)
        );

        assign port.alloc_valid = enc_valid;
        assign port.alloc_tag   = enc_tag;

        // allocated and released tags never collide, so the order is free
        always_ff @(posedge clk) begin
                if (reset) begin
                        busy_q <= busy_init;
                end else begin
                        if (port.alloc_take) begin
                                busy_q[port.alloc_tag] <= 1'b1;
                        end
                        if (port.release_valid) begin
                                busy_q[port.release_tag] <= 1'b0;
                        end
                end
        end

endmodule

`default_nettype wire

/* rtl/freelist_enc64.sv */
`default_nettype none

`include "rename_cfg.svh"

module freelist_enc64 (
        input  prf_pkg::prf_vec_t free_list,
        output logic              free_valid,
        output prf_pkg::prf_tag_t free_num
);
        import prf_pkg::*;

        // first-zero search, lowest index wins
        always_comb begin
                free_valid = 1'b0;
                free_num   = '0;
                // walk down so the last hit is the lowest clear bit
                for (int i = `PRF_NUM - 1; i >= 0; i--) begin
                        if (!free_list[i]) begin
                                free_valid = 1'b1;
                                free_num   = prf_tag_t'(i);
                        end
                end
        end

endmodule

`default_nettype wire

/* rtl/prf_pkg.sv */
`default_nettype none

`include "rename_cfg.svh"

package prf_pkg;

        // one physical register tag
        typedef logic [`PRF_NUM_WIDTH-1:0] prf_tag_t;

        // busy vector, bit set means the tag is in use
        typedef logic [`PRF_NUM-1:0] prf_vec_t;

        // result of one rename
        typedef struct packed {
                prf_tag_t src_tag;
                prf_tag_t dest_tag;
                prf_tag_t old_tag;
        } renamed_t;

endpackage

`default_nettype wire

/* rtl/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// physical register file
`define PRF_NUM 64
`define PRF_NUM_WIDTH 6

// architectural register file
`define ARF_NUM 32
`define ARF_NUM_WIDTH 5

`endif

/* rtl/rename_if.sv */
`default_nettype none

`include "rename_cfg.svh"

// allocation and release path of the free list
interface free_if;
        import prf_pkg::*;

        logic     alloc_valid;
        logic     alloc_take;
        prf_tag_t alloc_tag;
        logic     release_valid;
        prf_tag_t release_tag;

        modport provider (
                output alloc_valid,
                output alloc_tag,
                input  alloc_take,
                input  release_valid,
                input  release_tag
        );

        // release side comes from the commit port and not the stage
        modport consumer (
                input  alloc_valid,
                input  alloc_tag,
                output alloc_take
        );
endinterface

// lookup and update path of the map table
interface map_if;
        import arch_pkg::*;
        import prf_pkg::*;

        arch_reg_t rd_src;
        arch_reg_t rd_dest;
        prf_tag_t  src_tag;
        prf_tag_t  old_tag;
        logic      wr_en;
        arch_reg_t wr_arch;
        prf_tag_t  wr_tag;

        modport tbl (
                input  rd_src,
                input  rd_dest,
                output src_tag,
                output old_tag,
                input  wr_en,
                input  wr_arch,
                input  wr_tag
        );

        modport user (
                output rd_src,
                output rd_dest,
                input  src_tag,
                input  old_tag,
                output wr_en,
                output wr_arch,
                output wr_tag
        );
endinterface

`default_nettype wire

/* rtl/rename_stage.sv */
`default_nettype none

`include "rename_cfg.svh"

module rename_stage (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 req_valid,
        output logic                 req_ready,
        input  arch_pkg::rename_req_t req,
        output logic                 out_valid,
        input  logic                 out_ready,
        output prf_pkg::renamed_t    out,
        free_if.consumer             fl,
        map_if.user                  map
);
        import prf_pkg::*;

        logic     out_valid_q;
        renamed_t out_q;
        renamed_t out_d;
        logic     slot_free;
        logic     accept;

        // output slot can take a new result this cycle
        assign slot_free = !out_valid_q || out_ready;
        assign req_ready = fl.alloc_valid && slot_free;
        assign accept    = req_valid && req_ready;

        // allocation happens on the accept edge
        assign fl.alloc_take = accept;

        // table lookups
        assign map.rd_src  = req.src;
        assign map.rd_dest = req.dest;

        // new mapping for dest that the next request sees
        assign map.wr_en   = accept;
        assign map.wr_arch = req.dest;
        assign map.wr_tag  = fl.alloc_tag;

        always_comb begin
                out_d.src_tag  = map.src_tag;
                out_d.dest_tag = fl.alloc_tag;
                out_d.old_tag  = map.old_tag;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        out_valid_q <= 1'b0;
                end else if (accept) begin
                        out_valid_q <= 1'b1;
                end else if (out_ready) begin
                        out_valid_q <= 1'b0;
                end
        end

        // payload only moves on accept and holds under back-pressure
        always_ff @(posedge clk) begin
                if (accept) begin
                        out_q <= out_d;
                end
        end

        assign out_valid = out_valid_q;
        assign out       = out_q;

endmodule

`default_nettype wire

/* rtl/rename_table.sv */
`default_nettype none

`include "rename_cfg.svh"

module rename_table (
        input  logic clk,
        input  logic reset,
        map_if.tbl   port
);
        import prf_pkg::*;

        prf_tag_t map_q [`ARF_NUM];

        // reads see the contents before this cycle's write
        assign port.src_tag = map_q[port.rd_src];
        assign port.old_tag = map_q[port.rd_dest];

        always_ff @(posedge clk) begin
                if (reset) begin
                        // identity map with arch reg i in phys reg i
                        for (int i = 0; i < `ARF_NUM; i++) begin
                                map_q[i] <= prf_tag_t'(i);
                        end
                end else if (port.wr_en) begin
                        map_q[port.wr_arch] <= port.wr_tag;
                end
        end

endmodule

`default_nettype wire

/* rtl/rename_top.sv */
`default_nettype none

`include "rename_cfg.svh"

module rename_top (
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      req_valid,
        output logic                      req_ready,
        input  logic [`ARF_NUM_WIDTH-1:0] req_dest,
        input  logic [`ARF_NUM_WIDTH-1:0] req_src,
        output logic                      out_valid,
        input  logic                      out_ready,
        output logic [`PRF_NUM_WIDTH-1:0] out_src_tag,
        output logic [`PRF_NUM_WIDTH-1:0] out_dest_tag,
        output logic [`PRF_NUM_WIDTH-1:0] out_old_tag,
        input  logic                      rel_valid,
        input  logic [`PRF_NUM_WIDTH-1:0] rel_tag
);
        import arch_pkg::*;
        import prf_pkg::*;

        rename_req_t req;
        renamed_t    out;

        free_if fl_bus ();
        map_if  map_bus ();

        assign req.dest = req_dest;
        assign req.src  = req_src;

        assign out_src_tag  = out.src_tag;
        assign out_dest_tag = out.dest_tag;
        assign out_old_tag  = out.old_tag;

        // commit-side release goes straight to the free list
        assign fl_bus.release_valid = rel_valid;
        assign fl_bus.release_tag   = rel_tag;

        rename_stage i_stage (
                .clk       (clk),
                .reset     (reset),
                .req_valid (req_valid),
                .req_ready (req_ready),
                .req       (req),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out       (out),
                .fl        (fl_bus.consumer),
                .map       (map_bus.user)
        );

        freelist i_freelist (
                .clk   (clk),
                .reset (reset),
                .port  (fl_bus.provider)
        );

        rename_table i_table (
                .clk   (clk),
                .reset (reset),
                .port  (map_bus.tbl)
        );

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/arch_pkg.sv
rtl/prf_pkg.sv
rtl/rename_if.sv
rtl/freelist_enc64.sv
rtl/freelist.sv
rtl/rename_table.sv
rtl/rename_stage.sv
rtl/rename_top.sv
verif/rename_checker.sv
verif/tb_rename.sv

/* verif/rename_checker.sv */
`default_nettype none

`include "rename_cfg.svh"

module rename_checker (
        input  logic              clk,
        input  logic              reset,
        input  logic              req_ready,
        input  logic              out_valid,
        input  logic              out_ready,
        input  prf_pkg::prf_tag_t out_src_tag,
        input  prf_pkg::prf_tag_t out_dest_tag,
        input  prf_pkg::prf_tag_t out_old_tag,
        output int                error_total
);
        timeunit 1ns;
        timeprecision 100ps;

        import prf_pkg::*;

        // results the model expects in order of acceptance
        renamed_t expected_q [$];
        string    test_name = "none";
        int       test_checks = 0;
        int       test_errors = 0;
        int       check_total = 0;
        int       test_count = 0;
        int       err_count = 0;
        logic     was_stalled = 1'b0;
        renamed_t held;

        assign error_total = err_count;

        task automatic begin_test(input string name);
                test_name   = name;
                test_checks = 0;
                test_errors = 0;
        endtask

        task automatic note_failure(input string what);
                $display("test %s: %s", test_name, what);
                test_errors++;
                err_count++;
        endtask

        task automatic expect_result(input renamed_t r);
                expected_q.push_back(r);
        endtask

        task automatic compare_field(input string field, input prf_tag_t expected,
                                     input prf_tag_t actual);
                test_checks++;
                check_total++;
                if (actual !== expected) begin
                        $display("Error %s: %s expected %0d, actual %0d",
                                 test_name, field, expected, actual);
                        test_errors++;
                        err_count++;
                end
        endtask

        task automatic end_test();
                // anything left over never made it out
                if (expected_q.size() != 0) begin
                        note_failure($sformatf("%0d results never reached the output",
                                               expected_q.size()));
                end
                test_count++;
                $display("test %s: %0d checks, %0d errors", test_name, test_checks,
                         test_errors);
        endtask

        task automatic report_totals();
                $display("tests %0d, checks %0d, errors %0d", test_count, check_total,
                         err_count);
        endtask

        // sample mid-cycle ahead of the handshake edge
        always @(negedge clk) begin
                renamed_t exp;
                if (reset) begin
                        expected_q.delete();
                        was_stalled = 1'b0;
                end else begin
                        if (was_stalled) begin
                                if (!out_valid) begin
                                        note_failure(
                                                "out_valid dropped before the result was consumed");
                                end else if ({out_src_tag, out_dest_tag, out_old_tag}
                                             !== held) begin
                                        note_failure("output fields changed under back-pressure");
                                end
                        end
                        if (out_valid && !out_ready && req_ready) begin
                                note_failure("req_ready is high while the output is stalled");
                        end
                        if (out_valid && out_ready) begin
                                if (expected_q.size() == 0) begin
                                        note_failure(
                                                "output handshake with no request outstanding");
                                end else begin
                                        exp = expected_q.pop_front();
                                        compare_field("src_tag", exp.src_tag, out_src_tag);
                                        compare_field("dest_tag", exp.dest_tag, out_dest_tag);
                                        compare_field("old_tag", exp.old_tag, out_old_tag);
                                end
                        end
                        was_stalled = out_valid && !out_ready;
                        held        = {out_src_tag, out_dest_tag, out_old_tag};
                end
        end

endmodule

`default_nettype wire

/* verif/tb_rename.sv */
`default_nettype none

`include "rename_cfg.svh"

module tb_rename;
        timeunit 1ns;
        timeprecision 100ps;

        import arch_pkg::*;
        import prf_pkg::*;

        // requests per test
        localparam int N_RESET_MAP    = 16;
        localparam int N_LOWEST       = 24;
        localparam int N_EXHAUST      = `PRF_NUM - `ARF_NUM + 1;
        localparam int N_REUSE        = 24;
        localparam int N_BACKPRESSURE = 24;
        localparam int N_RANDOM       = 500;
        localparam int REQ_TOTAL = N_RESET_MAP + N_LOWEST + N_EXHAUST + N_REUSE
                                 + N_BACKPRESSURE + N_RANDOM;
        localparam int CYCLE_LIMIT = REQ_TOTAL * 4 + 200;

        logic      clk = 1'b0;
        logic      reset;
        logic      req_valid;
        logic      req_ready;
        arch_reg_t req_dest;
        arch_reg_t req_src;
        logic      out_valid;
        logic      out_ready;
        prf_tag_t  out_src_tag;
        prf_tag_t  out_dest_tag;
        prf_tag_t  out_old_tag;
        logic      rel_valid;
        prf_tag_t  rel_tag;
        int        error_total;
        int        cycle_count = 0;

        // reference model
        prf_vec_t    model_busy;
        prf_tag_t    model_map [`ARF_NUM];
        prf_tag_t    releasable [$];
        logic        model_out_valid;
        logic [31:0] rng_state = 32'ha599_58b1;

        always #4 clk = ~clk;

        rename_top i_rename_top (
                .clk          (clk),
                .reset        (reset),
                .req_valid    (req_valid),
                .req_ready    (req_ready),
                .req_dest     (req_dest),
                .req_src      (req_src),
                .out_valid    (out_valid),
                .out_ready    (out_ready),
                .out_src_tag  (out_src_tag),
                .out_dest_tag (out_dest_tag),
                .out_old_tag  (out_old_tag),
                .rel_valid    (rel_valid),
                .rel_tag      (rel_tag)
        );

        rename_checker i_checker (
                .clk          (clk),
                .reset        (reset),
                .req_ready    (req_ready),
                .out_valid    (out_valid),
                .out_ready    (out_ready),
                .out_src_tag  (out_src_tag),
                .out_dest_tag (out_dest_tag),
                .out_old_tag  (out_old_tag),
                .error_total  (error_total)
        );

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("timeout: the run did not finish within %0d cycles",
                                 CYCLE_LIMIT);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        function automatic logic [31:0] xorshift32();
                logic [31:0] x;
                x = rng_state;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rng_state = x;
                return x;
        endfunction

        function automatic prf_tag_t lowest_free();
                prf_tag_t tag;
                tag = '0;
                for (int i = 0; i < `PRF_NUM; i++) begin
                        if (!model_busy[i]) begin
                                tag = prf_tag_t'(i);
                                break;
                        end
                end
                return tag;
        endfunction

        task automatic model_reset();
                model_busy = {{(`PRF_NUM - `ARF_NUM){1'b0}}, {`ARF_NUM{1'b1}}};
                for (int i = 0; i < `ARF_NUM; i++) begin
                        model_map[i] = prf_tag_t'(i);
                end
                releasable.delete();
                model_out_valid = 1'b0;
        endtask

        // source and old dest are read before the new mapping lands
        task automatic model_accept(input arch_reg_t dest, input arch_reg_t src);
                renamed_t exp;
                exp.src_tag  = model_map[src];
                exp.old_tag  = model_map[dest];
                exp.dest_tag = lowest_free();
                model_busy[exp.dest_tag] = 1'b1;
                model_map[dest] = exp.dest_tag;
                releasable.push_back(exp.old_tag);
                i_checker.expect_result(exp);
        endtask

        // one clock with the model update mid-cycle and the drive after the edge
        task automatic run_cycle(output logic accepted);
                logic exp_ready;
                @(negedge clk);
                exp_ready = (~&model_busy) && (!model_out_valid || out_ready);
                i_checker.compare_field("req_ready", prf_tag_t'(exp_ready),
                                        prf_tag_t'(req_ready));
                i_checker.compare_field("out_valid", prf_tag_t'(model_out_valid),
                                        prf_tag_t'(out_valid));
                accepted = req_valid && req_ready;
                if (accepted) begin
                        model_accept(req_dest, req_src);
                        model_out_valid = 1'b1;
                end else if (out_ready) begin
                        model_out_valid = 1'b0;
                end
                // a release frees the tag only after this edge
                if (rel_valid) begin
                        model_busy[rel_tag] = 1'b0;
                end
                @(posedge clk);
                #1;
                rel_valid = 1'b0;
        endtask

        task automatic start_release(input int idx);
                rel_tag   = releasable[idx];
                rel_valid = 1'b1;
                releasable.delete(idx);
        endtask

        task automatic send_req(input arch_reg_t dest, input arch_reg_t src);
                logic acc;
                req_valid = 1'b1;
                req_dest  = dest;
                req_src   = src;
                acc       = 1'b0;
                while (!acc) begin
                        run_cycle(acc);
                end
                req_valid = 1'b0;
        endtask

        task automatic apply_reset();
                reset     = 1'b1;
                req_valid = 1'b0;
                rel_valid = 1'b0;
                out_ready = 1'b1;
                repeat (5) @(posedge clk);
                #1;
                reset = 1'b0;
                model_reset();
                if (out_valid !== 1'b0 || req_ready !== 1'b1) begin
                        i_checker.note_failure("out_valid or req_ready wrong after reset");
                end
        endtask

        task automatic drain();
                logic acc;
                req_valid = 1'b0;
                out_ready = 1'b1;
                run_cycle(acc);
                while (out_valid) begin
                        run_cycle(acc);
                end
        endtask

        task automatic run_reset_map();
                i_checker.begin_test("reset_map");
                apply_reset();
                // src equals dest and both tags come from the identity map
                for (int i = 0; i < N_RESET_MAP; i++) begin
                        send_req(arch_reg_t'(i), arch_reg_t'(i));
                end
                drain();
                i_checker.end_test();
        endtask

        task automatic run_lowest_free();
                logic [31:0] rnd;
                i_checker.begin_test("lowest_free");
                apply_reset();
                for (int n = 0; n < N_LOWEST; n++) begin
                        rnd = xorshift32();
                        send_req(rnd[`ARF_NUM_WIDTH-1:0], rnd[`ARF_NUM_WIDTH+7:8]);
                end
                drain();
                i_checker.end_test();
        endtask

        task automatic run_exhaustion();
                logic        acc;
                logic [31:0] rnd;
                i_checker.begin_test("exhaustion");
                apply_reset();
                for (int n = 0; n < N_EXHAUST - 1; n++) begin
                        rnd = xorshift32();
                        send_req(rnd[`ARF_NUM_WIDTH-1:0], rnd[`ARF_NUM_WIDTH+7:8]);
                end
                rnd       = xorshift32();
                req_valid = 1'b1;
                req_dest  = rnd[`ARF_NUM_WIDTH-1:0];
                req_src   = rnd[`ARF_NUM_WIDTH+7:8];
                repeat (6) begin
                        run_cycle(acc);
                        if (acc) begin
                                i_checker.note_failure("request accepted with every tag busy");
                        end
                end
                start_release(0);
                run_cycle(acc);
                if (acc) begin
                        i_checker.note_failure("request accepted in the same cycle as the release");
                end
                run_cycle(acc);
                if (!acc) begin
                        i_checker.note_failure("req_ready stayed low after a release");
                end
                drain();
                i_checker.end_test();
        endtask

        task automatic run_release_reuse();
                logic [31:0] rnd;
                i_checker.begin_test("release_reuse");
                apply_reset();
                for (int n = 0; n < N_REUSE; n++) begin
                        rnd = xorshift32();
                        // released tags sit below the upper half and come back first
                        if (n >= 8 && n % 2 == 0 && releasable.size() > 0) begin
                                start_release(int'(rnd[31:16]) % releasable.size());
                        end
                        send_req(rnd[`ARF_NUM_WIDTH-1:0], rnd[`ARF_NUM_WIDTH+7:8]);
                end
                drain();
                i_checker.end_test();
        endtask

        task automatic run_back_pressure();
                logic        acc;
                logic [31:0] rnd;
                int          sent;
                i_checker.begin_test("back_pressure");
                apply_reset();
                sent = 0;
                acc  = 1'b1;
                while (sent < N_BACKPRESSURE) begin
                        rnd = xorshift32();
                        if (acc) begin
                                req_valid = 1'b1;
                                req_dest  = rnd[`ARF_NUM_WIDTH-1:0];
                                req_src   = rnd[`ARF_NUM_WIDTH+7:8];
                        end
                        out_ready = rnd[16];
                        run_cycle(acc);
                        if (acc) begin
                                sent++;
                        end
                end
                drain();
                i_checker.end_test();
        endtask

        task automatic run_random_mix();
                logic        acc;
                logic [31:0] rnd;
                i_checker.begin_test("random_mix");
                apply_reset();
                acc = 1'b1;
                for (int c = 0; c < N_RANDOM; c++) begin
                        rnd = xorshift32();
                        // a pending request holds until it is taken
                        if (!req_valid || acc) begin
                                req_valid = (rnd[2:0] < 3'd5);
                                req_dest  = rnd[`ARF_NUM_WIDTH+7:8];
                                req_src   = rnd[`ARF_NUM_WIDTH+15:16];
                        end
                        out_ready = (rnd[4:3] != 2'b00);
                        if (rnd[6:5] == 2'b00 && releasable.size() > 0) begin
                                start_release(int'(rnd[31:21]) % releasable.size());
                        end
                        run_cycle(acc);
                end
                drain();
                i_checker.end_test();
        endtask

        initial begin
                reset     = 1'b1;
                req_valid = 1'b0;
                req_dest  = '0;
                req_src   = '0;
                out_ready = 1'b1;
                rel_valid = 1'b0;
                rel_tag   = '0;
                run_reset_map();
                run_lowest_free();
                run_exhaustion();
                run_release_reuse();
                run_back_pressure();
                run_random_mix();
                i_checker.report_totals();
                if (error_total == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire
